// ==== src/phy_types_pkg.sv ====
// Symbol widths, K28 comma codes and selector types shared by the PHY receive decoder
`default_nettype none

package phy_types_pkg;

    // Bits per 8b/10b encoded symbol
    localparam int SYMBOL_WIDTH = 10;

    // Tells how the sender framed the word
    typedef enum logic [1:0] {
        SELECT_COMMA_1_FLIT = 2'd0,
        SELECT_COMMA_2_FLIT = 2'd1,
        SELECT_COMMA_DATA   = 2'd2
    } comma_length_sel_t;

    // RD- forms, laid out as abcdei_fghj with a in the MSB
    localparam logic [SYMBOL_WIDTH-1:0] START_COMMA          = 10'b001111_1010; // K28.5
    localparam logic [SYMBOL_WIDTH-1:0] END_COMMA            = 10'b001111_1001; // K28.1
    localparam logic [SYMBOL_WIDTH-1:0] GRTCRED0_COMMA       = 10'b001111_0101; // K28.2
    localparam logic [SYMBOL_WIDTH-1:0] GRTCRED1_COMMA       = 10'b001111_0011; // K28.3
    localparam logic [SYMBOL_WIDTH-1:0] NACK_CTRL_BAUD_COMMA = 10'b001111_0010; // K28.4

    // Two-symbol commas, matched on symbol 1 only
    localparam logic [SYMBOL_WIDTH-1:0] ACK_COMMA            = 10'b001111_0100; // K28.0
    localparam logic [SYMBOL_WIDTH-1:0] BAUD_COMMA           = 10'b001111_0110; // K28.6
    localparam logic [SYMBOL_WIDTH-1:0] REQ_CTRL_BAUD_COMMA  = 10'b001111_1000; // K28.7
    localparam logic [SYMBOL_WIDTH-1:0] GRT_CTRL_BAUD_COMMA  = 10'b001111_0101; // K28.2

    typedef enum logic [3:0] {
        START_PACKET_SEL   = 4'd0,
        END_PACKET_SEL     = 4'd1,
        GRTCRED0_SEL       = 4'd2,
        GRTCRED1_SEL       = 4'd3,
        NACK_CTRL_BAUD_SEL = 4'd4,
        ACK_SEL            = 4'd5,
        BAUD_SEL           = 4'd6,
        REQ_CTRL_BAUD_SEL  = 4'd7,
        GRT_CTRL_BAUD_SEL  = 4'd8,
        DATA_SEL           = 4'd9
    } comma_sel_t;

endpackage

`default_nettype wire

// ==== src/chiplet_types_pkg.sv ====
// Flit, metadata and header layouts of the chiplet link, with the packet length rule
`default_nettype none

package chiplet_types_pkg;

    localparam int PAYLOAD_WIDTH    = 32;
    localparam int PKT_LENGTH_WIDTH = 5;

    // Any other format value is read as a response
    localparam logic [3:0] FMT_SHORT_REQ = 4'h1;

    typedef struct packed {
        logic       vc;
        logic [1:0] id;
        logic [4:0] req;
    } metadata_t;

    // Symbol 4 lands in metadata, symbol 0 in payload[7:0]
    typedef struct packed {
        metadata_t                metadata;
        logic [PAYLOAD_WIDTH-1:0] payload;
    } flit_t;

    typedef struct packed {
        logic [3:0]  fmt;
        logic [3:0]  length;
        logic [23:0] addr;
    } short_hdr_t;

    typedef struct packed {
        logic [3:0]  fmt;
        logic [3:0]  status;
        logic [23:0] tag;
    } resp_hdr_t;

    typedef union packed {
        short_hdr_t short_req;
        resp_hdr_t  resp;
    } hdr_view_u;

    // Total flits in the packet, header flit included
    function automatic logic [PKT_LENGTH_WIDTH-1:0] expected_num_flits(input hdr_view_u hdr);
        logic [PKT_LENGTH_WIDTH-1:0] num;
        if (hdr.short_req.fmt == FMT_SHORT_REQ) begin
            num = PKT_LENGTH_WIDTH'(hdr.short_req.length) + PKT_LENGTH_WIDTH'(2);
        end else begin
            // Responses are a single header flit
            num = PKT_LENGTH_WIDTH'(1);
        end
        return num;
    endfunction

endpackage

`default_nettype wire

// ==== src/dec_8b10b.sv ====
// Combinational 8b/10b symbol decoder, one instance per received symbol lane
`timescale 1ns/1ps
`default_nettype none

module dec_8b10b (
    input  logic [phy_types_pkg::SYMBOL_WIDTH-1:0] symbol,
    output logic [7:0]                             data,
    output logic                                   is_k,
    output logic                                   code_err
);
    logic [5:0] sub6;
    logic [3:0] sub4;
    logic [4:0] dec5;
    logic [2:0] dec3;
    logic       err6;
    logic       err4;

    assign sub6 = symbol[9:4];
    assign is_k = (sub6 == 6'b001111) || (sub6 == 6'b110000);

    // K28 in RD+ form has its fghj inverted against the data table
    assign sub4 = (sub6 == 6'b110000) ? ~symbol[3:0] : symbol[3:0];

    // 5b/6b, both disparities
    always_comb begin
        err6 = 1'b0;
        case (sub6)
            6'b100111, 6'b011000: dec5 = 5'd0;
            6'b011101, 6'b100010: dec5 = 5'd1;
            6'b101101, 6'b010010: dec5 = 5'd2;
            6'b110001:            dec5 = 5'd3;
            6'b110101, 6'b001010: dec5 = 5'd4;
            6'b101001:            dec5 = 5'd5;
            6'b011001:            dec5 = 5'd6;
            6'b111000, 6'b000111: dec5 = 5'd7;
            6'b111001, 6'b000110: dec5 = 5'd8;
            6'b100101:            dec5 = 5'd9;
            6'b010101:            dec5 = 5'd10;
            6'b110100:            dec5 = 5'd11;
            6'b001101:            dec5 = 5'd12;
            6'b101100:            dec5 = 5'd13;
            6'b011100:            dec5 = 5'd14;
            6'b010111, 6'b101000: dec5 = 5'd15;
            6'b011011, 6'b100100: dec5 = 5'd16;
            6'b100011:            dec5 = 5'd17;
            6'b010011:            dec5 = 5'd18;
            6'b110010:            dec5 = 5'd19;
            6'b001011:            dec5 = 5'd20;
            6'b101010:            dec5 = 5'd21;
            6'b011010:            dec5 = 5'd22;
            6'b111010, 6'b000101: dec5 = 5'd23;
            6'b110011, 6'b001100: dec5 = 5'd24;
            6'b100110:            dec5 = 5'd25;
            6'b010110:            dec5 = 5'd26;
            6'b110110, 6'b001001: dec5 = 5'd27;
            6'b001110:            dec5 = 5'd28;
            6'b101110, 6'b010001: dec5 = 5'd29;
            6'b011110, 6'b100001: dec5 = 5'd30;
            6'b101011, 6'b010100: dec5 = 5'd31;
            6'b001111, 6'b110000: dec5 = 5'd28;
            default: begin
                dec5 = 5'd0;
                err6 = 1'b1;
            end
        endcase
    end

    // 3b/4b, alternate D.x.7 forms accepted as well
    always_comb begin
        err4 = 1'b0;
        case (sub4)
            4'b1011, 4'b0100:                   dec3 = 3'd0;
            4'b1001:                            dec3 = 3'd1;
            4'b0101:                            dec3 = 3'd2;
            4'b1100, 4'b0011:                   dec3 = 3'd3;
            4'b1101, 4'b0010:                   dec3 = 3'd4;
            4'b1010:                            dec3 = 3'd5;
            4'b0110:                            dec3 = 3'd6;
            4'b1110, 4'b0001, 4'b0111, 4'b1000: dec3 = 3'd7;
            default: begin
                dec3 = 3'd0;
                err4 = 1'b1;
            end
        endcase
    end

    assign data     = {dec3, dec5};
    assign code_err = err6 || err4;

endmodule

`default_nettype wire

// ==== src/comma_classifier.sv ====
// Turns raw comma symbols into a comma selection and forms the next flit, metadata included
`timescale 1ns/1ps
`default_nettype none

module comma_classifier (
    input  logic                                     done,
    input  phy_types_pkg::comma_length_sel_t         comma_length_sel,
    input  logic [2*phy_types_pkg::SYMBOL_WIDTH-1:0] raw_lo,
    input  chiplet_types_pkg::flit_t                 dec_flit,
    input  chiplet_types_pkg::flit_t                 curr_flit,
    input  phy_types_pkg::comma_sel_t                curr_comma_sel,
    output chiplet_types_pkg::flit_t                 next_flit,
    output phy_types_pkg::comma_sel_t                next_comma_sel,
    output logic                                     comma_err
);
    import phy_types_pkg::*;

    logic [SYMBOL_WIDTH-1:0] raw_sym0;
    logic [SYMBOL_WIDTH-1:0] raw_sym1;

    assign raw_sym0 = raw_lo[SYMBOL_WIDTH-1:0];
    assign raw_sym1 = raw_lo[2*SYMBOL_WIDTH-1:SYMBOL_WIDTH];

    always_comb begin
        next_flit      = curr_flit;
        next_comma_sel = curr_comma_sel;
        comma_err      = 1'b0;

        if (done) begin
            case (comma_length_sel)
                SELECT_COMMA_1_FLIT: begin
                    case (raw_sym0)
                        START_COMMA:          next_comma_sel = START_PACKET_SEL;
                        END_COMMA:            next_comma_sel = END_PACKET_SEL;
                        GRTCRED0_COMMA:       next_comma_sel = GRTCRED0_SEL;
                        GRTCRED1_COMMA:       next_comma_sel = GRTCRED1_SEL;
                        NACK_CTRL_BAUD_COMMA: next_comma_sel = NACK_CTRL_BAUD_SEL;
                        default:              comma_err = 1'b1;
                    endcase
                end

                SELECT_COMMA_2_FLIT: begin
                    // Metadata rides in decoded symbol 0, old payload stays
                    next_flit.metadata.vc  = dec_flit.payload[7];
                    next_flit.metadata.id  = dec_flit.payload[6:5];
                    next_flit.metadata.req = dec_flit.payload[4:0];

                    case (raw_sym1)
                        ACK_COMMA:           next_comma_sel = ACK_SEL;
                        BAUD_COMMA:          next_comma_sel = BAUD_SEL;
                        REQ_CTRL_BAUD_COMMA: next_comma_sel = REQ_CTRL_BAUD_SEL;
                        GRT_CTRL_BAUD_COMMA: next_comma_sel = GRT_CTRL_BAUD_SEL;
                        default:             comma_err = 1'b1;
                    endcase
                end

                SELECT_COMMA_DATA: begin
                    next_flit      = dec_flit;
                    next_comma_sel = DATA_SEL;
                end

                // Illegal selector
                default: comma_err = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/packet_order_fsm.sv ====
// Checks that packets arrive as start comma, data, end comma and flags words out of order
`timescale 1ns/1ps
`default_nettype none

module packet_order_fsm (
    input  logic                                   CLK,
    input  logic                                   nRST,
    input  logic                                   done,
    input  phy_types_pkg::comma_length_sel_t       comma_length_sel,
    input  logic [phy_types_pkg::SYMBOL_WIDTH-1:0] raw_sym0,
    output logic                                   order_err,
    output logic                                   data_expected
);
    import phy_types_pkg::*;

    typedef enum logic [1:0] {
        LOOK_FOR_START,
        LOOK_FOR_DATA,
        LOOK_FOR_END
    } order_state_t;

    order_state_t state;
    order_state_t next_state;
    logic         is_data;
    logic         is_comma;
    logic         is_start;
    logic         is_end;

    assign is_data  = done && (comma_length_sel == SELECT_COMMA_DATA);
    assign is_comma = done && ((comma_length_sel == SELECT_COMMA_1_FLIT) ||
                               (comma_length_sel == SELECT_COMMA_2_FLIT));
    assign is_start = done && (comma_length_sel == SELECT_COMMA_1_FLIT) &&
                      (raw_sym0 == START_COMMA);
    assign is_end   = done && (comma_length_sel == SELECT_COMMA_1_FLIT) &&
                      (raw_sym0 == END_COMMA);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= LOOK_FOR_START;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        order_err  = 1'b0;
        case (state)
            LOOK_FOR_START: begin
                // Link commas between packets are fine
                if (is_start) begin
                    next_state = LOOK_FOR_DATA;
                end else if (is_data) begin
                    order_err = 1'b1;
                end
            end
            LOOK_FOR_DATA: begin
                if (is_data) begin
                    next_state = LOOK_FOR_END;
                end else if (is_comma) begin
                    order_err = 1'b1;
                end
            end
            LOOK_FOR_END: begin
                if (is_end) begin
                    next_state = LOOK_FOR_START;
                end else if (is_comma) begin
                    order_err = 1'b1;
                    // Missing end comma, new packet begins anyway
                    if (is_start) begin
                        next_state = LOOK_FOR_DATA;
                    end
                end
            end
            default: next_state = LOOK_FOR_START;
        endcase
    end

    assign data_expected = (state == LOOK_FOR_DATA);

endmodule

`default_nettype wire

// ==== src/packet_size_counter.sv ====
// Counts the flits still to come in the current packet, loaded from the header flit
`timescale 1ns/1ps
`default_nettype none

module packet_size_counter (
    input  logic                                         CLK,
    input  logic                                         nRST,
    input  logic                                         done,
    input  phy_types_pkg::comma_length_sel_t             comma_length_sel,
    input  logic                                         data_expected,
    input  logic [chiplet_types_pkg::PAYLOAD_WIDTH-1:0]  payload,
    output logic [chiplet_types_pkg::PKT_LENGTH_WIDTH-1:0] curr_packet_size
);
    import phy_types_pkg::*;
    import chiplet_types_pkg::*;

    hdr_view_u                   hdr;
    logic [PKT_LENGTH_WIDTH-1:0] next_size;

    assign hdr = payload;

    always_comb begin
        next_size = curr_packet_size;
        if (done) begin
            case (comma_length_sel)
                SELECT_COMMA_1_FLIT, SELECT_COMMA_2_FLIT: next_size = '0;
                SELECT_COMMA_DATA: begin
                    if (data_expected) begin
                        next_size = expected_num_flits(hdr) - PKT_LENGTH_WIDTH'(1);
                    end else if (curr_packet_size != '0) begin
                        next_size = curr_packet_size - PKT_LENGTH_WIDTH'(1);
                    end
                end
                default: next_size = curr_packet_size;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            curr_packet_size <= '0;
        end else begin
            curr_packet_size <= next_size;
        end
    end

endmodule

`default_nettype wire

// ==== src/wrap_dec_8b_10b.sv ====
// Receive-side top that decodes a word of symbols and registers flit, comma selection and errors
`timescale 1ns/1ps
`default_nettype none

module wrap_dec_8b_10b #(
    parameter int PORTCOUNT = 5
) (
    input  logic                                            CLK,
    input  logic                                            nRST,
    input  logic                                            done,
    input  logic                                            err,
    input  logic [PORTCOUNT*phy_types_pkg::SYMBOL_WIDTH-1:0] enc_flit,
    input  phy_types_pkg::comma_length_sel_t                comma_length_sel,
    output logic                                            done_out,
    output chiplet_types_pkg::flit_t                        flit,
    output phy_types_pkg::comma_sel_t                       comma_sel,
    output logic                                            err_out,
    output logic [chiplet_types_pkg::PKT_LENGTH_WIDTH-1:0]  curr_packet_size
);
    import phy_types_pkg::*;
    import chiplet_types_pkg::*;

    logic [PORTCOUNT*8-1:0] dec_word;
    logic [PORTCOUNT-1:0]   sym_code_err;
    logic [PORTCOUNT-1:0]   sym_is_k;
    flit_t                  dec_flit;
    flit_t                  next_flit;
    comma_sel_t             next_comma_sel;
    logic                   comma_err;
    logic                   order_err;
    logic                   data_expected;
    logic                   data_word;
    logic                   next_err;

    for (genvar i = 0; i < PORTCOUNT; i++) begin : g_dec
        dec_8b10b u_dec (
            .symbol   (enc_flit[i*SYMBOL_WIDTH +: SYMBOL_WIDTH]),
            .data     (dec_word[i*8 +: 8]),
            .is_k     (sym_is_k[i]),
            .code_err (sym_code_err[i])
        );
    end

    assign dec_flit = dec_word;

    comma_classifier u_comma_classifier (
        .done             (done),
        .comma_length_sel (comma_length_sel),
        .raw_lo           (enc_flit[2*SYMBOL_WIDTH-1:0]),
        .dec_flit         (dec_flit),
        .curr_flit        (flit),
        .curr_comma_sel   (comma_sel),
        .next_flit        (next_flit),
        .next_comma_sel   (next_comma_sel),
        .comma_err        (comma_err)
    );

    packet_order_fsm u_packet_order_fsm (
        .CLK              (CLK),
        .nRST             (nRST),
        .done             (done),
        .comma_length_sel (comma_length_sel),
        .raw_sym0         (enc_flit[SYMBOL_WIDTH-1:0]),
        .order_err        (order_err),
        .data_expected    (data_expected)
    );

    packet_size_counter u_packet_size_counter (
        .CLK              (CLK),
        .nRST             (nRST),
        .done             (done),
        .comma_length_sel (comma_length_sel),
        .data_expected    (data_expected),
        .payload          (dec_flit.payload),
        .curr_packet_size (curr_packet_size)
    );

    assign data_word = (comma_length_sel == SELECT_COMMA_DATA);

    // A control character inside a data word counts as a bad symbol too
    assign next_err = err ||
                      (done && (order_err || comma_err ||
                                (data_word && |(sym_code_err | sym_is_k))));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            done_out  <= 1'b0;
            flit      <= '0;
            comma_sel <= START_PACKET_SEL;
            err_out   <= 1'b0;
        end else begin
            done_out  <= done;
            flit      <= next_flit;
            comma_sel <= next_comma_sel;
            err_out   <= next_err;
        end
    end

endmodule

`default_nettype wire

// ==== tb/wrap_dec_8b_10b_checker.sv ====
// Concurrent assertions on output timing and reset values, bound into the decoder top
`timescale 1ns/1ps
`default_nettype none

module wrap_dec_8b_10b_checker (
    input logic                                           CLK,
    input logic                                           nRST,
    input logic                                           done,
    input phy_types_pkg::comma_length_sel_t               comma_length_sel,
    input logic                                           done_out,
    input chiplet_types_pkg::flit_t                       flit,
    input phy_types_pkg::comma_sel_t                      comma_sel,
    input logic                                           err_out,
    input logic [chiplet_types_pkg::PKT_LENGTH_WIDTH-1:0] curr_packet_size
);
    import phy_types_pkg::*;

    // Number of failed assertions so far
    int assert_fails = 0;

    done_delay: assert property (@(posedge CLK) disable iff (!nRST)
        done_out == $past(done))
    else begin
        assert_fails++;
        $error("done_out is not done delayed by one cycle");
    end

    hold_without_done: assert property (@(posedge CLK) disable iff (!nRST)
        !$past(done) |-> ($stable(flit) && $stable(comma_sel)))
    else begin
        assert_fails++;
        $error("flit or comma_sel changed without a strobe");
    end

    reset_values: assert property (@(posedge CLK)
        $rose(nRST) |-> (!done_out && !err_out && flit == '0 &&
                         curr_packet_size == '0 && comma_sel == START_PACKET_SEL))
    else begin
        assert_fails++;
        $error("outputs left their reset values too early");
    end

    legal_selector: assert property (@(posedge CLK) disable iff (!nRST)
        done |-> (comma_length_sel inside {SELECT_COMMA_1_FLIT, SELECT_COMMA_2_FLIT,
                                           SELECT_COMMA_DATA}))
    else begin
        assert_fails++;
        $error("illegal comma_length_sel with done high");
    end

endmodule

bind wrap_dec_8b_10b wrap_dec_8b_10b_checker u_checker (
    .CLK              (CLK),
    .nRST             (nRST),
    .done             (done),
    .comma_length_sel (comma_length_sel),
    .done_out         (done_out),
    .flit             (flit),
    .comma_sel        (comma_sel),
    .err_out          (err_out),
    .curr_packet_size (curr_packet_size)
);

`default_nettype wire

// ==== tb/wrap_dec_8b_10b_tb.sv ====
// Testbench that replays words from the tests file into the decoder top and checks the results
`timescale 1ns/1ps
`default_nettype none

module wrap_dec_8b_10b_tb;
    import phy_types_pkg::*;
    import chiplet_types_pkg::*;

    localparam int          PORTCOUNT     = 5;
    localparam int          FIELDS        = PORTCOUNT + 7;
    localparam int          MAX_VECTORS   = 64;
    localparam int          RESET_TIMEOUT = 50;
    localparam logic [63:0] END_MARK      = '1;

    logic                              CLK;
    logic                              nRST;
    logic                              done;
    logic                              err;
    logic [PORTCOUNT*SYMBOL_WIDTH-1:0] enc_flit;
    comma_length_sel_t                 comma_length_sel;
    logic                              done_out;
    flit_t                             flit;
    comma_sel_t                        comma_sel;
    logic                              err_out;
    logic [PKT_LENGTH_WIDTH-1:0]       curr_packet_size;

    // FIELDS entries per word
    logic [63:0] vectors [0:MAX_VECTORS*FIELDS-1];
    int          errors;
    int          num_vectors;
    int          wait_cycles;
    int          i;

    wrap_dec_8b_10b #(
        .PORTCOUNT (PORTCOUNT)
    ) uut (
        .CLK              (CLK),
        .nRST             (nRST),
        .done             (done),
        .err              (err),
        .enc_flit         (enc_flit),
        .comma_length_sel (comma_length_sel),
        .done_out         (done_out),
        .flit             (flit),
        .comma_sel        (comma_sel),
        .err_out          (err_out),
        .curr_packet_size (curr_packet_size)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic apply_word(input int idx);
        int base;
        int k;
        base             = idx * FIELDS;
        done             = vectors[base][0];
        err              = vectors[base+1][0];
        comma_length_sel = comma_length_sel_t'(vectors[base+2][1:0]);
        // Lanes are listed from the highest one down to lane 0
        for (k = 0; k < PORTCOUNT; k++) begin
            enc_flit[k*SYMBOL_WIDTH +: SYMBOL_WIDTH] =
                vectors[base+2+PORTCOUNT-k][SYMBOL_WIDTH-1:0];
        end
    endtask

    task automatic compare_word(input int idx);
        int base;
        base = idx * FIELDS + PORTCOUNT + 3;
        check_value($sformatf("word %0d done_out", idx), 64'(done_out), vectors[idx*FIELDS]);
        check_value($sformatf("word %0d flit", idx), 64'(flit), vectors[base]);
        check_value($sformatf("word %0d comma_sel", idx), 64'(comma_sel), vectors[base+1]);
        check_value($sformatf("word %0d err_out", idx), 64'(err_out), vectors[base+2]);
        check_value($sformatf("word %0d curr_packet_size", idx), 64'(curr_packet_size),
                    vectors[base+3]);
    endtask

    initial begin
        done             = 1'b0;
        err              = 1'b0;
        enc_flit         = '0;
        comma_length_sel = SELECT_COMMA_1_FLIT;
        errors           = 0;
        num_vectors      = 0;
        wait_cycles      = 0;

        for (i = 0; i < MAX_VECTORS*FIELDS; i++) begin
            vectors[i] = END_MARK;
        end
        $readmemh("tb/wrap_dec_tests.txt", vectors);
        while (num_vectors < MAX_VECTORS && vectors[num_vectors*FIELDS] != END_MARK) begin
            num_vectors++;
        end

        while (nRST !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
            @(posedge CLK);
            wait_cycles++;
        end
        if (nRST !== 1'b1) begin
            $display("Reset was still active after %0d cycles", wait_cycles);
            errors++;
        end else begin
            @(negedge CLK);
            check_value("reset done_out", 64'(done_out), 64'd0);
            check_value("reset flit", 64'(flit), 64'd0);
            check_value("reset comma_sel", 64'(comma_sel), 64'(START_PACKET_SEL));
            check_value("reset err_out", 64'(err_out), 64'd0);
            check_value("reset curr_packet_size", 64'(curr_packet_size), 64'd0);

            if (num_vectors == 0) begin
                $display("No words could be read from the tests file");
                errors++;
            end

            // Results of a word show up at the next falling edge
            for (i = 0; i < num_vectors; i++) begin
                apply_word(i);
                @(negedge CLK);
                compare_word(i);
            end
        end
        done = 1'b0;
        err  = 1'b0;
        @(negedge CLK);

        $display("Words: %0d, mismatches: %0d, assertion failures: %0d",
                 num_vectors, errors, uut.u_checker.assert_fails);
        if (errors == 0 && uut.u_checker.assert_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/wrap_dec_tests.txt ====
// done err sel sym4 sym3 sym2 sym1 sym0, then expected flit comma_sel err_out curr_packet_size
// sel 0 is a one-symbol comma, 1 a two-symbol comma, 2 data; symbols are raw 10-bit codes
0 0 0 000 000 000 000 000 0000000000 0 0 00
1 0 0 0FA 0FA 0FA 0FA 0FA 0000000000 0 0 00 // start
1 0 2 1D9 13B 295 316 159 211245C32A 9 0 03 // header, length field 2
1 0 2 295 159 1D9 15B 316 452A210AC3 9 0 02
1 0 2 13B 316 295 159 1D9 12C3452A21 9 0 01
1 0 0 0F9 0F9 0F9 0F9 0F9 12C3452A21 1 0 00 // end
1 0 0 0F5 0F5 0F5 0F5 0F5 12C3452A21 2 0 00
1 0 0 0F3 0F3 0F3 0F3 0F3 12C3452A21 3 0 00
1 0 0 0F2 0F2 0F2 0F2 0F2 12C3452A21 4 0 00
1 0 1 0F4 0F4 0F4 0F4 159 2AC3452A21 5 0 00 // two-symbol commas carry metadata
1 0 1 0F6 0F6 0F6 0F6 316 C3C3452A21 6 0 00
1 0 1 0F8 0F8 0F8 0F8 295 45C3452A21 7 0 00
1 0 1 0F5 0F5 0F5 0F5 1D9 21C3452A21 8 0 00
0 0 0 000 000 000 000 000 21C3452A21 8 0 00
1 0 2 1D9 159 295 316 13B 212A45C312 9 1 00 // data before start
1 0 0 0FA 0FA 0FA 0FA 0FA 212A45C312 0 0 00
1 0 2 159 1BB 316 295 1D9 2A10C34521 9 0 01 // header, length field 0
1 0 0 0F2 0F2 0F2 0F2 0F2 2A10C34521 4 1 00 // link comma inside packet
1 0 0 0FA 0FA 0FA 0FA 0FA 2A10C34521 0 1 00 // start where end belongs
1 0 2 316 159 1D9 13B 295 C32A211245 9 0 00 // response header resumes packet
1 0 0 0F9 0F9 0F9 0F9 0F9 C32A211245 1 0 00
1 0 0 0FA 0FA 0FA 0FA 0FA C32A211245 0 0 00
1 0 1 0F4 0F4 0F4 0F4 13B 122A211245 5 1 00 // two-symbol comma before data
1 0 2 1D9 23B 159 316 295 21112AC345 9 0 02 // header, length field 1
1 0 2 159 159 159 159 000 2A2A2A2A00 9 1 01 // invalid symbol in lane 0
1 0 0 0F9 0F9 0F9 0F9 0F9 2A2A2A2A00 1 0 00
1 0 0 0F6 0F6 0F6 0F6 0F6 2A2A2A2A00 1 1 00 // unknown one-symbol code
1 0 1 0F9 0F9 0F9 0F9 1D9 212A2A2A00 1 1 00 // unknown two-symbol code
0 1 0 000 000 000 000 000 212A2A2A00 1 1 00 // upstream error, no strobe
1 1 0 0FA 0FA 0FA 0FA 0FA 212A2A2A00 0 1 00
1 0 2 13B 316 159 1D9 295 12C32A2145 9 0 00 // response header
1 0 0 0F9 0F9 0F9 0F9 0F9 12C32A2145 1 0 00
0 0 0 000 000 000 000 000 12C32A2145 1 0 00

// ==== files.f ====
src/phy_types_pkg.sv
src/chiplet_types_pkg.sv
src/dec_8b10b.sv
src/comma_classifier.sv
src/packet_order_fsm.sv
src/packet_size_counter.sv
src/wrap_dec_8b_10b.sv
tb/wrap_dec_8b_10b_checker.sv
tb/wrap_dec_8b_10b_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := wrap_dec_8b_10b_tb
RTL_TOP    := wrap_dec_8b_10b
FILELIST   := files.f
BUILD_DIR  := obj_dir
RUN_ARGS   := +verilator+error+limit+1000
PASS_MSG   := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
